/* hdl/core_pkg.sv */
package core_pkg;

	// base and custom opcodes.
	localparam logic [6:0] OP_RTYPE      = 7'b0110011;
	localparam logic [6:0] OP_ITYPE      = 7'b0010011;
	localparam logic [6:0] OP_ITYPE_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STYPE      = 7'b0100011;
	localparam logic [6:0] OP_BTYPE      = 7'b1100011;
	localparam logic [6:0] OP_JAL        = 7'b1101111;
	localparam logic [6:0] OP_JALR       = 7'b1100111;
	localparam logic [6:0] OP_LUI        = 7'b0110111;
	localparam logic [6:0] OP_AUIPC      = 7'b0010111;
	localparam logic [6:0] OP_ITYPE_CSR  = 7'b1110011;
	localparam logic [6:0] OP_AES_STYPE  = 7'b0001011; // custom-0 space.

	// {funct7[5], funct3} so r-type maps straight through.
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101,
		ALU_B    = 4'b1111
	} alu_op_t;

	typedef enum logic [3:0] {
		IMM_I          = 4'd0,
		IMM_S          = 4'd1,
		IMM_B          = 4'd2,
		IMM_J          = 4'd3,
		IMM_U          = 4'd4,
		IMM_AES_BLOCK  = 4'd5,
		IMM_AES_KEY    = 4'd6,
		IMM_AES_CONFIG = 4'd7,
		IMM_AES_CTRL   = 4'd8,
		IMM_AES_RESULT = 4'd9,
		IMM_NONE       = 4'd15
	} imm_sel_t;

	typedef enum logic [1:0] {
		WB_MEM = 2'b00,
		WB_ALU = 2'b01,
		WB_PC4 = 2'b10
	} wb_sel_t;

	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [2:0] F3_AES_BLOCK  = 3'b000;
	localparam logic [2:0] F3_AES_KEY    = 3'b001;
	localparam logic [2:0] F3_AES_CONFIG = 3'b010;
	localparam logic [2:0] F3_AES_START  = 3'b011;
	localparam logic [2:0] F3_AES_RESULT = 3'b100;

	localparam logic [11:0] MRET_IMM = 12'h302;

endpackage

/* hdl/inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer #(
	parameter int BUF_DEPTH = 4
) (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic        in_valid_i,
	input  logic [31:0] in_pc_i,
	input  logic [31:0] in_inst_i,
	output logic        head_valid_o,
	output logic [31:0] head_pc_o,
	output logic [31:0] head_inst_o,
	output logic        credit_o
);

	localparam int PTR_W = $clog2(BUF_DEPTH);
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(BUF_DEPTH - 1);

	logic [31:0]      pc_mem   [BUF_DEPTH];
	logic [31:0]      inst_mem [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	assign pop          = (count != '0); // nothing stalls downstream.
	assign head_valid_o = pop;
	assign head_pc_o    = pc_mem[rd_ptr];
	assign head_inst_o  = inst_mem[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (in_valid_i) begin
			pc_mem[wr_ptr]   <= in_pc_i;
			inst_mem[wr_ptr] <= in_inst_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (in_valid_i)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count    <= count + CNT_W'(in_valid_i) - CNT_W'(pop);
			credit_o <= pop; // one credit back per entry that leaves.
		end
	end

endmodule

/* hdl/ctrl_unit.sv */
`timescale 1ns/1ps

module ctrl_unit (
	input  logic [31:0]        inst_i,
	output logic               reg_we_o,
	output core_pkg::alu_op_t  alu_sel_o,
	output logic               b_sel_o,
	output logic               a_sel_o,
	output core_pkg::imm_sel_t imm_sel_o,
	output logic               mem_we_o,
	output core_pkg::wb_sel_t  wb_sel_o,
	output logic               br_un_o,
	output logic               valid_cache_o,
	output logic               valid_aes_o,
	output logic               is_mret_o,
	output logic               csr_we_o
);

	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_csr;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign is_csr = (opcode == OP_ITYPE_CSR);

	// stores, branches and aes stores have no rd.
	assign reg_we_o = !((opcode == OP_STYPE) || (opcode == OP_BTYPE) ||
		(opcode == OP_AES_STYPE) || (is_csr && inst_i[11:7] == 5'd0));

	always_comb begin
		if ((opcode == OP_BTYPE) || (opcode == OP_JAL) || (opcode == OP_JALR) ||
			(opcode == OP_ITYPE_LOAD) || (opcode == OP_STYPE) || (opcode == OP_AUIPC) ||
			(opcode == OP_AES_STYPE) || (is_csr && funct3[1:0] == 2'b01))
			alu_sel_o = ALU_ADD; // address and target math.
		else if (opcode == OP_LUI)
			alu_sel_o = ALU_B;
		else if (is_csr && funct3[1:0] == 2'b11)
			alu_sel_o = ALU_AND;
		else if (is_csr && funct3[1:0] == 2'b10)
			alu_sel_o = ALU_OR;
		else if (opcode == OP_ITYPE && funct3 != 3'b101)
			alu_sel_o = alu_op_t'({1'b0, funct3}); // imm bit 10 only matters for srai.
		else
			alu_sel_o = alu_op_t'({funct7[5], funct3});
	end

	always_comb begin
		case (opcode)
			OP_ITYPE, OP_JALR, OP_ITYPE_LOAD, OP_ITYPE_CSR: imm_sel_o = IMM_I;
			OP_STYPE:          imm_sel_o = IMM_S;
			OP_BTYPE:          imm_sel_o = IMM_B;
			OP_JAL:            imm_sel_o = IMM_J;
			OP_LUI, OP_AUIPC:  imm_sel_o = IMM_U;
			OP_AES_STYPE: begin
				case (funct3)
					F3_AES_BLOCK:  imm_sel_o = IMM_AES_BLOCK;
					F3_AES_KEY:    imm_sel_o = IMM_AES_KEY;
					F3_AES_CONFIG: imm_sel_o = IMM_AES_CONFIG;
					F3_AES_START:  imm_sel_o = IMM_AES_CTRL;
					F3_AES_RESULT: imm_sel_o = IMM_AES_RESULT;
					default:       imm_sel_o = IMM_NONE;
				endcase
			end
			default:           imm_sel_o = IMM_NONE;
		endcase
	end

	always_comb begin
		if (opcode == OP_ITYPE_LOAD)
			wb_sel_o = WB_MEM;
		else if ((opcode == OP_JAL) || (opcode == OP_JALR))
			wb_sel_o = WB_PC4; // link address.
		else
			wb_sel_o = WB_ALU;
	end

	assign b_sel_o       = !((opcode == OP_RTYPE) || is_csr);
	assign a_sel_o       = (opcode == OP_BTYPE) || (opcode == OP_JAL) || (opcode == OP_AUIPC);
	assign mem_we_o      = (opcode == OP_STYPE);
	assign br_un_o       = (funct3 == F3_BLTU) || (funct3 == F3_BGEU);
	assign valid_cache_o = (opcode == OP_ITYPE_LOAD) || (opcode == OP_STYPE);
	assign valid_aes_o   = (opcode == OP_AES_STYPE);
	assign is_mret_o     = is_csr && (inst_i[31:20] == MRET_IMM);
	assign csr_we_o      = is_csr;

endmodule

/* hdl/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
	input  logic [31:0]        inst_i,
	input  core_pkg::imm_sel_t imm_sel_i,
	output logic [31:0]        imm_o
);

	import core_pkg::*;

	logic [31:0] imm_s;

	// aes kinds reuse the store layout as a register offset.
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

	always_comb begin
		case (imm_sel_i)
			IMM_I: imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
			IMM_S: imm_o = imm_s;
			IMM_B: imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
				inst_i[11:8], 1'b0};
			IMM_J: imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
				inst_i[30:21], 1'b0};
			IMM_U: imm_o = {inst_i[31:12], 12'b0};
			IMM_AES_BLOCK, IMM_AES_KEY, IMM_AES_CONFIG,
			IMM_AES_CTRL, IMM_AES_RESULT: imm_o = imm_s;
			default: imm_o = 32'd0;
		endcase
	end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic [4:0]  rs1_i,
	input  logic [4:0]  rs2_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o,
	input  logic        we_i,
	input  logic [4:0]  rd_i,
	input  logic [31:0] rd_data_i
);

	logic [31:0] regs [32];

	assign rs1_data_o = regs[rs1_i];
	assign rs2_data_o = regs[rs2_i];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (we_i && rd_i != 5'd0) begin // x0 stays zero.
			regs[rd_i] <= rd_data_i;
		end
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic [31:0]       a_i,
	input  logic [31:0]       b_i,
	input  core_pkg::alu_op_t op_i,
	output logic [31:0]       y_o
);

	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
			ALU_ADD:  y_o = a_i + b_i;
			ALU_SUB:  y_o = a_i - b_i;
			ALU_SLL:  y_o = a_i << shamt;
			ALU_SLT:  y_o = {31'd0, $signed(a_i) < $signed(b_i)};
			ALU_SLTU: y_o = {31'd0, a_i < b_i};
			ALU_XOR:  y_o = a_i ^ b_i;
			ALU_SRL:  y_o = a_i >> shamt;
			ALU_SRA:  y_o = $unsigned($signed(a_i) >>> shamt);
			ALU_OR:   y_o = a_i | b_i;
			ALU_AND:  y_o = a_i & b_i;
			ALU_B:    y_o = b_i; // lui.
			default:  y_o = 32'd0;
		endcase
	end

endmodule

/* hdl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               head_valid_i,
	input  logic [31:0]        pc_i,
	input  logic [31:0]        inst_i,
	input  logic [31:0]        rs1_data_i,
	input  logic [31:0]        rs2_data_i,
	input  logic [31:0]        imm_i,
	input  logic               reg_we_i,
	input  core_pkg::alu_op_t  alu_sel_i,
	input  logic               b_sel_i,
	input  logic               a_sel_i,
	input  core_pkg::imm_sel_t imm_sel_i,
	input  logic               mem_we_i,
	input  core_pkg::wb_sel_t  wb_sel_i,
	input  logic               br_un_i,
	input  logic               valid_cache_i,
	input  logic               valid_aes_i,
	input  logic               is_mret_i,
	input  logic               csr_we_i,
	output logic               rf_we_o,
	output logic [4:0]         rf_rd_o,
	output logic [31:0]        rf_wdata_o,
	output logic               mem_valid_o,
	output logic               mem_we_o,
	output logic [31:0]        mem_addr_o,
	output logic [31:0]        mem_wdata_o,
	input  logic [31:0]        mem_rdata_i,
	output logic               aes_valid_o,
	output core_pkg::imm_sel_t aes_kind_o,
	output logic [31:0]        aes_addr_o,
	output logic [31:0]        aes_data_o,
	output logic               ret_valid_o,
	output logic [31:0]        ret_pc_o,
	output logic               ret_rd_we_o,
	output logic [4:0]         ret_rd_o,
	output logic [31:0]        ret_rd_data_o,
	output logic               ret_br_taken_o,
	output logic [31:0]        ret_target_o,
	output logic               ret_mret_o
);

	import core_pkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] op_a, op_b, alu_y, target;
	logic        br_eq, br_lt, br_cond, taken;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign op_a   = a_sel_i ? pc_i : rs1_data_i;
	assign op_b   = b_sel_i ? imm_i : rs2_data_i;

	alu u_alu (
		.a_i  (op_a),
		.b_i  (op_b),
		.op_i (alu_sel_i),
		.y_o  (alu_y)
	);

	assign br_eq = (rs1_data_i == rs2_data_i);
	assign br_lt = br_un_i ? (rs1_data_i < rs2_data_i) : ($signed(rs1_data_i) < $signed(rs2_data_i));

	always_comb begin
		case (funct3)
			F3_BEQ:           br_cond = br_eq;
			F3_BNE:           br_cond = !br_eq;
			F3_BLT, F3_BLTU:  br_cond = br_lt;
			F3_BGE, F3_BGEU:  br_cond = !br_lt;
			default:          br_cond = 1'b0;
		endcase
	end

	assign taken  = ((opcode == OP_BTYPE) && br_cond) || (opcode == OP_JAL) || (opcode == OP_JALR);
	assign target = (opcode == OP_JALR) ? {alu_y[31:1], 1'b0} : alu_y;

	// no csr file here, so a csr read returns zero.
	always_comb begin
		if (csr_we_i)
			rf_wdata_o = 32'd0;
		else begin
			case (wb_sel_i)
				WB_MEM:  rf_wdata_o = mem_rdata_i;
				WB_PC4:  rf_wdata_o = pc_i + 32'd4;
				default: rf_wdata_o = alu_y;
			endcase
		end
	end

	assign rf_we_o     = reg_we_i && head_valid_i;
	assign rf_rd_o     = inst_i[11:7];
	assign mem_valid_o = valid_cache_i && head_valid_i;
	assign mem_we_o    = mem_we_i && head_valid_i;
	assign mem_addr_o  = alu_y;
	assign mem_wdata_o = rs2_data_i;
	assign aes_valid_o = valid_aes_i && head_valid_i;
	assign aes_kind_o  = imm_sel_i;
	assign aes_addr_o  = alu_y; // rs1 plus register offset.
	assign aes_data_o  = rs2_data_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ret_valid_o    <= 1'b0;
			ret_rd_we_o    <= 1'b0;
			ret_br_taken_o <= 1'b0;
			ret_mret_o     <= 1'b0;
		end else begin
			ret_valid_o    <= head_valid_i;
			ret_rd_we_o    <= rf_we_o;
			ret_br_taken_o <= taken && head_valid_i;
			ret_mret_o     <= is_mret_i && head_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		ret_pc_o      <= pc_i;
		ret_rd_o      <= rf_rd_o;
		ret_rd_data_o <= rf_wdata_o;
		ret_target_o  <= target;
	end

endmodule

/* hdl/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top #(
	parameter int BUF_DEPTH = 4
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               inst_valid_i,
	input  logic [31:0]        pc_i,
	input  logic [31:0]        inst_i,
	output logic               credit_o,
	output logic               mem_valid_o,
	output logic               mem_we_o,
	output logic [31:0]        mem_addr_o,
	output logic [31:0]        mem_wdata_o,
	input  logic [31:0]        mem_rdata_i,
	output logic               aes_valid_o,
	output core_pkg::imm_sel_t aes_kind_o,
	output logic [31:0]        aes_addr_o,
	output logic [31:0]        aes_data_o,
	output logic               ret_valid_o,
	output logic [31:0]        ret_pc_o,
	output logic               ret_rd_we_o,
	output logic [4:0]         ret_rd_o,
	output logic [31:0]        ret_rd_data_o,
	output logic               ret_br_taken_o,
	output logic [31:0]        ret_target_o,
	output logic               ret_mret_o
);

	import core_pkg::*;

	logic        head_valid;
	logic [31:0] head_pc, head_inst;
	logic [31:0] rs1_data, rs2_data, imm;
	logic        rf_we;
	logic [4:0]  rf_rd;
	logic [31:0] rf_wdata;
	logic        reg_we, b_sel, a_sel, mem_we, br_un;
	logic        valid_cache, valid_aes, is_mret, csr_we;
	alu_op_t     alu_sel;
	imm_sel_t    imm_sel;
	wb_sel_t     wb_sel;

	inst_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_inst_buffer (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.in_valid_i   (inst_valid_i),
		.in_pc_i      (pc_i),
		.in_inst_i    (inst_i),
		.head_valid_o (head_valid),
		.head_pc_o    (head_pc),
		.head_inst_o  (head_inst),
		.credit_o     (credit_o)
	);

	ctrl_unit u_ctrl_unit (
		.inst_i        (head_inst),
		.reg_we_o      (reg_we),
		.alu_sel_o     (alu_sel),
		.b_sel_o       (b_sel),
		.a_sel_o       (a_sel),
		.imm_sel_o     (imm_sel),
		.mem_we_o      (mem_we),
		.wb_sel_o      (wb_sel),
		.br_un_o       (br_un),
		.valid_cache_o (valid_cache),
		.valid_aes_o   (valid_aes),
		.is_mret_o     (is_mret),
		.csr_we_o      (csr_we)
	);

	imm_gen u_imm_gen (
		.inst_i    (head_inst),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	// write lands at the same edge that advances the head.
	reg_file u_reg_file (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_i      (head_inst[19:15]),
		.rs2_i      (head_inst[24:20]),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.we_i       (rf_we),
		.rd_i       (rf_rd),
		.rd_data_i  (rf_wdata)
	);

	exec_stage u_exec_stage (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.head_valid_i   (head_valid),
		.pc_i           (head_pc),
		.inst_i         (head_inst),
		.rs1_data_i     (rs1_data),
		.rs2_data_i     (rs2_data),
		.imm_i          (imm),
		.reg_we_i       (reg_we),
		.alu_sel_i      (alu_sel),
		.b_sel_i        (b_sel),
		.a_sel_i        (a_sel),
		.imm_sel_i      (imm_sel),
		.mem_we_i       (mem_we),
		.wb_sel_i       (wb_sel),
		.br_un_i        (br_un),
		.valid_cache_i  (valid_cache),
		.valid_aes_i    (valid_aes),
		.is_mret_i      (is_mret),
		.csr_we_i       (csr_we),
		.rf_we_o        (rf_we),
		.rf_rd_o        (rf_rd),
		.rf_wdata_o     (rf_wdata),
		.mem_valid_o    (mem_valid_o),
		.mem_we_o       (mem_we_o),
		.mem_addr_o     (mem_addr_o),
		.mem_wdata_o    (mem_wdata_o),
		.mem_rdata_i    (mem_rdata_i),
		.aes_valid_o    (aes_valid_o),
		.aes_kind_o     (aes_kind_o),
		.aes_addr_o     (aes_addr_o),
		.aes_data_o     (aes_data_o),
		.ret_valid_o    (ret_valid_o),
		.ret_pc_o       (ret_pc_o),
		.ret_rd_we_o    (ret_rd_we_o),
		.ret_rd_o       (ret_rd_o),
		.ret_rd_data_o  (ret_rd_data_o),
		.ret_br_taken_o (ret_br_taken_o),
		.ret_target_o   (ret_target_o),
		.ret_mret_o     (ret_mret_o)
	);

endmodule

/* verification/tb_rv_exec.sv */
`timescale 1ns/1ps

module tb_rv_exec;

	import core_pkg::*;

	localparam int BUF_DEPTH    = 4;
	localparam int N_ENTRIES    = 37;
	localparam int RESET_CYCLES = 10;

	typedef enum logic [2:0] {K_ALU, K_LOAD, K_STORE, K_BRANCH, K_AES, K_CSR} entry_kind_t;

	logic        clk_i = 1'b0;
	logic        reset_i;
	logic        inst_valid_i;
	logic [31:0] pc_i;
	logic [31:0] inst_i;
	logic        credit_o;
	logic        mem_valid_o;
	logic        mem_we_o;
	logic [31:0] mem_addr_o;
	logic [31:0] mem_wdata_o;
	logic [31:0] mem_rdata_i;
	logic        aes_valid_o;
	imm_sel_t    aes_kind_o;
	logic [31:0] aes_addr_o;
	logic [31:0] aes_data_o;
	logic        ret_valid_o;
	logic [31:0] ret_pc_o;
	logic        ret_rd_we_o;
	logic [4:0]  ret_rd_o;
	logic [31:0] ret_rd_data_o;
	logic        ret_br_taken_o;
	logic [31:0] ret_target_o;
	logic        ret_mret_o;

	// stimulus and expected values, one row per instruction.
	entry_kind_t tab_kind   [N_ENTRIES];
	logic [31:0] tab_pc     [N_ENTRIES];
	logic [31:0] tab_inst   [N_ENTRIES];
	logic        tab_rd_we  [N_ENTRIES];
	logic [4:0]  tab_rd     [N_ENTRIES];
	logic [31:0] tab_data   [N_ENTRIES];
	logic        tab_taken  [N_ENTRIES];
	logic [31:0] tab_target [N_ENTRIES];
	logic [31:0] tab_addr   [N_ENTRIES];
	imm_sel_t    tab_aes    [N_ENTRIES];
	logic        tab_mret   [N_ENTRIES];
	int          n_built = 0;
	int          ret_idx = 0;
	integer      seed;

	logic [31:0] dmem [64];

	logic        prev_mem_valid, prev_mem_we, prev_aes_valid;
	logic [31:0] prev_mem_addr, prev_mem_wdata, prev_aes_addr, prev_aes_data;
	imm_sel_t    prev_aes_kind;

	rv_exec_top #(
		.BUF_DEPTH (BUF_DEPTH)
	) uut (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.inst_valid_i   (inst_valid_i),
		.pc_i           (pc_i),
		.inst_i         (inst_i),
		.credit_o       (credit_o),
		.mem_valid_o    (mem_valid_o),
		.mem_we_o       (mem_we_o),
		.mem_addr_o     (mem_addr_o),
		.mem_wdata_o    (mem_wdata_o),
		.mem_rdata_i    (mem_rdata_i),
		.aes_valid_o    (aes_valid_o),
		.aes_kind_o     (aes_kind_o),
		.aes_addr_o     (aes_addr_o),
		.aes_data_o     (aes_data_o),
		.ret_valid_o    (ret_valid_o),
		.ret_pc_o       (ret_pc_o),
		.ret_rd_we_o    (ret_rd_we_o),
		.ret_rd_o       (ret_rd_o),
		.ret_rd_data_o  (ret_rd_data_o),
		.ret_br_taken_o (ret_br_taken_o),
		.ret_target_o   (ret_target_o),
		.ret_mret_o     (ret_mret_o)
	);

	always #10 clk_i = ~clk_i;

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_RTYPE};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BTYPE};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_rd(input string what, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_aes_kind(input string what, input imm_sel_t got, input imm_sel_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, got.name(),
				exp.name());
			abort_run();
		end
	endtask

	task automatic push(input entry_kind_t kind, input logic [31:0] inst, input logic rd_we,
		input logic [4:0] rd, input logic [31:0] data, input logic taken,
		input logic [31:0] target, input logic [31:0] addr, input imm_sel_t aes_kind,
		input logic mret);
		tab_kind[n_built]   = kind;
		tab_pc[n_built]     = 32'h100 + 32'(4 * n_built); // straight-line pcs.
		tab_inst[n_built]   = inst;
		tab_rd_we[n_built]  = rd_we;
		tab_rd[n_built]     = rd;
		tab_data[n_built]   = data;
		tab_taken[n_built]  = taken;
		tab_target[n_built] = target;
		tab_addr[n_built]   = addr;
		tab_aes[n_built]    = aes_kind;
		tab_mret[n_built]   = mret;
		n_built++;
	endtask

	task automatic alu_entry(input logic [31:0] inst, input logic [4:0] rd,
		input logic [31:0] data);
		push(K_ALU, inst, 1'b1, rd, data, 1'b0, '0, '0, IMM_NONE, 1'b0);
	endtask

	task automatic load_entry(input logic [31:0] inst, input logic [4:0] rd,
		input logic [31:0] data, input logic [31:0] addr);
		push(K_LOAD, inst, 1'b1, rd, data, 1'b0, '0, addr, IMM_NONE, 1'b0);
	endtask

	task automatic store_entry(input logic [31:0] inst, input logic [31:0] data,
		input logic [31:0] addr);
		push(K_STORE, inst, 1'b0, 5'd0, data, 1'b0, '0, addr, IMM_NONE, 1'b0);
	endtask

	task automatic branch_entry(input logic [31:0] inst, input logic rd_we, input logic [4:0] rd,
		input logic [31:0] data, input logic taken, input logic [31:0] target);
		push(K_BRANCH, inst, rd_we, rd, data, taken, target, '0, IMM_NONE, 1'b0);
	endtask

	task automatic aes_entry(input logic [31:0] inst, input imm_sel_t kind,
		input logic [31:0] data, input logic [31:0] addr);
		push(K_AES, inst, 1'b0, 5'd0, data, 1'b0, '0, addr, kind, 1'b0);
	endtask

	task automatic csr_entry(input logic [31:0] inst, input logic rd_we, input logic [4:0] rd,
		input logic mret);
		push(K_CSR, inst, rd_we, rd, 32'd0, 1'b0, '0, '0, IMM_NONE, mret);
	endtask

	task automatic build_table();
		// x1 = 5, x2 = -3 feed the r-type and branch rows.
		alu_entry(i_type(12'd5, 5'd0, 3'b000, 5'd1, OP_ITYPE), 5'd1, 32'd5);
		alu_entry(i_type(12'hFFD, 5'd0, 3'b000, 5'd2, OP_ITYPE), 5'd2, 32'hFFFFFFFD);
		alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'd2);
		alu_entry(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'd8);
		alu_entry(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd5), 5'd5, 32'hFFFFFFFF);
		alu_entry(r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd6), 5'd6, 32'h07FFFFFF);
		alu_entry(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd7), 5'd7, 32'd1);
		alu_entry(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd8), 5'd8, 32'd0);
		alu_entry(r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd9), 5'd9, 32'hA0);
		alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), 5'd10, 32'hFFFFFFF8);
		alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 5'd11, 32'hFFFFFFFD);
		alu_entry(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 5'd12, 32'd5);
		alu_entry({20'h12345, 5'd13, OP_LUI}, 5'd13, 32'h12345000);
		alu_entry({20'h00001, 5'd14, OP_AUIPC}, 5'd14, 32'h1134);
		alu_entry(i_type(12'd7, 5'd1, 3'b000, 5'd0, OP_ITYPE), 5'd0, 32'd12);
		alu_entry(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd15), 5'd15, 32'd5); // x0 still zero.
		alu_entry(i_type(12'h040, 5'd0, 3'b000, 5'd16, OP_ITYPE), 5'd16, 32'h40);
		store_entry(s_type(12'd4, 5'd4, 5'd16, 3'b010, OP_STYPE), 32'd8, 32'h44);
		load_entry(i_type(12'd4, 5'd16, 3'b010, 5'd17, OP_ITYPE_LOAD), 5'd17, 32'd8, 32'h44);
		load_entry(i_type(12'd0, 5'd16, 3'b010, 5'd18, OP_ITYPE_LOAD), 5'd18, 32'hC0DE0040,
			32'h40);
		branch_entry(b_type(13'd16, 5'd1, 5'd1, F3_BEQ), 1'b0, 5'd0, '0, 1'b1, 32'h160);
		branch_entry(b_type(13'd8, 5'd1, 5'd1, F3_BNE), 1'b0, 5'd0, '0, 1'b0, 32'h15C);
		branch_entry(b_type(13'h1FF8, 5'd1, 5'd2, F3_BLT), 1'b0, 5'd0, '0, 1'b1, 32'h150);
		branch_entry(b_type(13'd12, 5'd1, 5'd2, F3_BLTU), 1'b0, 5'd0, '0, 1'b0, 32'h168);
		branch_entry(b_type(13'd32, 5'd1, 5'd2, F3_BGEU), 1'b0, 5'd0, '0, 1'b1, 32'h180);
		branch_entry(b_type(13'd4, 5'd2, 5'd1, F3_BGE), 1'b0, 5'd0, '0, 1'b1, 32'h168);
		branch_entry(j_type(21'h100, 5'd19), 1'b1, 5'd19, 32'h16C, 1'b1, 32'h268);
		branch_entry(i_type(12'h020, 5'd1, 3'b000, 5'd20, OP_JALR), 1'b1, 5'd20, 32'h170,
			1'b1, 32'h24);
		aes_entry(s_type(12'd0, 5'd4, 5'd16, F3_AES_BLOCK, OP_AES_STYPE), IMM_AES_BLOCK,
			32'd8, 32'h40);
		aes_entry(s_type(12'd4, 5'd13, 5'd16, F3_AES_KEY, OP_AES_STYPE), IMM_AES_KEY,
			32'h12345000, 32'h44);
		aes_entry(s_type(12'd8, 5'd2, 5'd16, F3_AES_CONFIG, OP_AES_STYPE), IMM_AES_CONFIG,
			32'hFFFFFFFD, 32'h48);
		aes_entry(s_type(12'd12, 5'd1, 5'd16, F3_AES_START, OP_AES_STYPE), IMM_AES_CTRL,
			32'd5, 32'h4C);
		aes_entry(s_type(12'h010, 5'd4, 5'd16, F3_AES_RESULT, OP_AES_STYPE), IMM_AES_RESULT,
			32'd8, 32'h50);
		csr_entry(i_type(MRET_IMM, 5'd0, 3'b000, 5'd0, OP_ITYPE_CSR), 1'b0, 5'd0, 1'b1);
		csr_entry(i_type(12'h305, 5'd1, 3'b001, 5'd0, OP_ITYPE_CSR), 1'b0, 5'd0, 1'b0);
		csr_entry(i_type(12'h300, 5'd0, 3'b010, 5'd21, OP_ITYPE_CSR), 1'b1, 5'd21, 1'b0);
		alu_entry(r_type(7'h00, 5'd18, 5'd17, 3'b000, 5'd22), 5'd22, 32'hC0DE0048);
	endtask

	task automatic check_retire();
		int i;
		i = ret_idx;
		if (i >= N_ENTRIES) begin
			$display("extra instruction retired at %0t ns after the whole table", $time);
			abort_run();
		end else begin
			check_word($sformatf("entry %0d retire pc", i), ret_pc_o, tab_pc[i]);
			check_bit($sformatf("entry %0d rd write", i), ret_rd_we_o, tab_rd_we[i]);
			if (tab_rd_we[i]) begin
				check_rd($sformatf("entry %0d rd", i), ret_rd_o, tab_rd[i]);
				check_word($sformatf("entry %0d rd data", i), ret_rd_data_o, tab_data[i]);
			end
			check_bit($sformatf("entry %0d taken", i), ret_br_taken_o, tab_taken[i]);
			if (tab_kind[i] == K_BRANCH)
				check_word($sformatf("entry %0d target", i), ret_target_o, tab_target[i]);
			check_bit($sformatf("entry %0d mret", i), ret_mret_o, tab_mret[i]);
			// requests were seen one cycle before the retire.
			check_bit($sformatf("entry %0d mem request", i), prev_mem_valid,
				tab_kind[i] == K_LOAD || tab_kind[i] == K_STORE);
			check_bit($sformatf("entry %0d aes request", i), prev_aes_valid,
				tab_kind[i] == K_AES);
			if (tab_kind[i] == K_LOAD || tab_kind[i] == K_STORE) begin
				check_bit($sformatf("entry %0d mem write", i), prev_mem_we,
					tab_kind[i] == K_STORE);
				check_word($sformatf("entry %0d mem addr", i), prev_mem_addr, tab_addr[i]);
			end
			if (tab_kind[i] == K_STORE)
				check_word($sformatf("entry %0d mem wdata", i), prev_mem_wdata, tab_data[i]);
			if (tab_kind[i] == K_AES) begin
				check_aes_kind($sformatf("entry %0d aes kind", i), prev_aes_kind, tab_aes[i]);
				check_word($sformatf("entry %0d aes data", i), prev_aes_data, tab_data[i]);
				check_word($sformatf("entry %0d aes addr", i), prev_aes_addr, tab_addr[i]);
			end
			ret_idx++;
		end
	endtask

	// data memory answers in the same cycle.
	initial begin
		for (int i = 0; i < 64; i++)
			dmem[i] = 32'hC0DE0000 | (i << 2);
	end

	assign mem_rdata_i = dmem[mem_addr_o[7:2]];

	always @(posedge clk_i) begin
		if (mem_valid_o && mem_we_o)
			dmem[mem_addr_o[7:2]] <= mem_wdata_o;
	end

	always @(negedge clk_i) begin
		if (!reset_i && ret_valid_o)
			check_retire();
		prev_mem_valid = mem_valid_o;
		prev_mem_we    = mem_we_o;
		prev_mem_addr  = mem_addr_o;
		prev_mem_wdata = mem_wdata_o;
		prev_aes_valid = aes_valid_o;
		prev_aes_kind  = aes_kind_o;
		prev_aes_addr  = aes_addr_o;
		prev_aes_data  = aes_data_o;
	end

	initial begin : watchdog
		repeat (RESET_CYCLES + 40 * N_ENTRIES) @(posedge clk_i);
		$display("timeout: retirement stalled after %0d of %0d instructions", ret_idx,
			N_ENTRIES);
		abort_run();
	end

	initial begin : stimulus
		int credits;
		int pulses;
		int sent;
		int gap;
		reset_i      = 1'b1;
		inst_valid_i = 1'b0;
		pc_i         = 32'd0;
		inst_i       = 32'd0;
		seed         = 50;
		credits      = BUF_DEPTH;
		pulses       = 0;
		sent         = 0;
		gap          = 0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk_i);
		reset_i <= 1'b0;
		while (ret_idx < N_ENTRIES) begin
			@(posedge clk_i);
			inst_valid_i <= 1'b0;
			if (credit_o) begin
				credits++;
				pulses++;
			end
			check_bit("credit count within buffer depth", credits <= BUF_DEPTH, 1'b1);
			if (sent < N_ENTRIES && gap == 0 && credits > 0) begin
				inst_valid_i <= 1'b1;
				pc_i         <= tab_pc[sent];
				inst_i       <= tab_inst[sent];
				credits--;
				sent++;
				gap = (sent < 6) ? 0 : $unsigned($random(seed)) % 4; // opening burst.
			end else if (gap > 0) begin
				gap--;
			end
		end
		// pulses that arrive after the last retire.
		repeat (BUF_DEPTH) begin
			@(posedge clk_i);
			if (credit_o)
				pulses++;
		end
		check_word("credit pulses", pulses, N_ENTRIES);
		check_word("stored word in data memory", dmem[17], 32'd8);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* src.f */
hdl/core_pkg.sv
hdl/inst_buffer.sv
hdl/ctrl_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_stage.sv
hdl/rv_exec_top.sv
verification/tb_rv_exec.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/inst_buffer.sv
      - hdl/ctrl_unit.sv
      - hdl/imm_gen.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/exec_stage.sv
      - hdl/rv_exec_top.sv
  - target: test
    files:
      - verification/tb_rv_exec.sv
